//--- bfcpu.f
+incdir+logic
logic/bfcpu_pkg.sv
logic/ctl_if.sv
logic/bus_capture.sv
logic/exec_datapath.sv
logic/sequencer.sv
logic/bfcpu.sv
tests/tb_clock.sv
tests/bfcpu_assert.sv
tests/tb_bfcpu.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the bfcpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_bfcpu -f bfcpu.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1

//--- tests/bfcpu_testdata.txt
// Row: stall flag, program length, opcode nibbles, input count, input bytes,
// expected output count, expected output bytes; first word is the test count
07
00 09 3 4 2 2 4 2 2 2 4 00 03 ff 01 04
00 0d 2 2 2 0 2 2 4 1 4 0 0 2 4 00 03 02 03 01
00 09 5 2 4 5 2 4 5 2 4 03 41 ff 10 03 42 00 11
00 0d 6 2 4 6 3 4 7 2 4 7 2 2 4 00 01 02
00 13 2 2 2 6 0 2 2 6 0 2 1 3 7 0 4 1 1 3 7 00 03 02 04 06
01 09 5 2 4 5 2 4 5 2 4 03 41 ff 10 03 42 00 11
01 13 2 2 2 6 0 2 2 6 0 2 1 3 7 0 4 1 1 3 7 00 03 02 04 06

//--- tests/tb_bfcpu.sv
//------------------------------
// Testbench for the bfcpu core
// Runs programs from the testdata file
// Program space modelled for 256 nibbles
// Run from the project root
//------------------------------
`timescale 1ns/1ns
`include "bfcpu_defs.svh"

module tb_bfcpu;

    logic               CLK;
    logic               RES;
    logic               reset_req;
    logic               if_req;
    logic [`PC_W-1:0]   if_addr;
    logic [`OP_W-1:0]   if_code;
    logic               if_rdy;
    logic               dm_req;
    logic               dm_write;
    logic [`PTR_W-1:0]  dm_addr;
    logic [`CELL_W-1:0] dm_wdata;
    logic [`CELL_W-1:0] dm_rdata;
    logic               dm_rdy;
    logic               io_req;
    logic               io_write;
    logic [`CELL_W-1:0] io_wdata;
    logic [`CELL_W-1:0] io_rdata;
    logic               io_rdy;

    // Test data and memory models
    logic [7:0]         tdata [0:255];
    int                 rp;
    logic [`OP_W-1:0]   prog [0:255];
    logic [`CELL_W-1:0] dmem [0:32767];
    logic [`CELL_W-1:0] in_q [$];
    logic [`CELL_W-1:0] out_q [$];
    logic               stall_on;
    logic [15:0]        lfsr = 16'd32414;
    int                 errors;
    int                 tests_run;
    logic               timed_out;

    tb_clock #(.PERIOD(8)) clock_i (.reset_req(reset_req), .CLK(CLK), .RES(RES));

    bfcpu bfcpu_i (
        .CLK(CLK), .RES(RES),
        .if_req(if_req), .if_addr(if_addr), .if_code(if_code), .if_rdy(if_rdy),
        .dm_req(dm_req), .dm_write(dm_write), .dm_addr(dm_addr),
        .dm_wdata(dm_wdata), .dm_rdata(dm_rdata), .dm_rdy(dm_rdy),
        .io_req(io_req), .io_write(io_write), .io_wdata(io_wdata),
        .io_rdata(io_rdata), .io_rdy(io_rdy)
    );

    // Galois LFSR with taps at 16 14 13 and 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    //------------------------------
    // Bus models
    //------------------------------
    // Read data appears one accepted cycle later and then holds
    always @(posedge CLK)
    begin
        if (!RES)
        begin
            if (if_req && if_rdy)
                if_code <= prog[if_addr[7:0]];
            if (dm_req && dm_rdy)
            begin
                if (dm_write)
                    dmem[dm_addr] <= dm_wdata;
                else
                    dm_rdata <= dmem[dm_addr];
            end
            if (io_req && io_rdy)
            begin
                if (io_write)
                    out_q.push_back(io_wdata);
                else if (in_q.size() > 0)
                    io_rdata <= in_q.pop_front();
                else
                    io_rdata <= 8'h00;
            end
        end
    end

    // Each ready level takes its own LFSR bit
    always @(posedge CLK)
    begin
        logic b_if;
        logic b_dm;
        logic b_io;
        b_if = lfsr[0];
        lfsr = lfsr_next(lfsr);
        b_dm = lfsr[0];
        lfsr = lfsr_next(lfsr);
        b_io = lfsr[0];
        lfsr = lfsr_next(lfsr);
        if_rdy <= stall_on ? ~b_if : 1'b1;
        dm_rdy <= stall_on ? ~b_dm : 1'b1;
        io_rdy <= stall_on ? ~b_io : 1'b1;
    end

    //------------------------------
    // Check and run tasks
    //------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("FAILED %s: got %0h expected %0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic read_item(output int v);
        v = int'(tdata[rp]);
        rp++;
    endtask

    task automatic run_test(input int num);
        int               plen;
        int               nin;
        int               nout;
        int               v;
        int               cycles;
        int               limit;
        int               err_before;
        logic             done;
        logic [7:0]       exp_q [$];
        err_before = errors;
        read_item(v);
        stall_on = (v != 0);
        read_item(plen);
        for (int i = 0; i < 256; i++)
            prog[i] = `OP_NOP;
        for (int i = 0; i < plen; i++)
        begin
            read_item(v);
            prog[i] = v[3:0];
        end
        read_item(nin);
        in_q.delete();
        for (int i = 0; i < nin; i++)
        begin
            read_item(v);
            in_q.push_back(v[7:0]);
        end
        read_item(nout);
        for (int i = 0; i < nout; i++)
        begin
            read_item(v);
            exp_q.push_back(v[7:0]);
        end
        // Reset and clear data memory while it is held
        @(posedge CLK);
        reset_req <= 1'b1;
        @(posedge RES);
        reset_req <= 1'b0;
        out_q.delete();
        for (int a = 0; a < 32768; a++)
            dmem[a] = 8'h00;
        wait (RES == 1'b0);
        // Run until the fetch just past the program is accepted
        limit  = 64 * plen * (stall_on ? 4 : 1);
        cycles = 0;
        done   = 1'b0;
        while (!done && !timed_out)
        begin
            @(posedge CLK);
            cycles++;
            if (if_req && if_rdy && if_addr == plen[`PC_W-1:0])
                done = 1'b1;
            else if (cycles > limit)
            begin
                $display("Test %0d did not finish within %0d cycles", num, limit);
                timed_out = 1'b1;
            end
        end
        // Let the last I/O write land
        @(negedge CLK);
        check_value("out_count", out_q.size(), nout);
        for (int i = 0; i < nout && i < out_q.size(); i++)
            check_value($sformatf("io_wdata[%0d]", i), out_q[i], exp_q[i]);
        tests_run++;
        $display("Test %0d %s in %0d cycles", num,
                 (errors == err_before && !timed_out) ? "passed" : "failed", cycles);
    endtask

    //------------------------------
    // Main sequence
    //------------------------------
    initial
    begin
        int ntests;
        reset_req = 1'b0;
        if_code   = `OP_NOP;
        dm_rdata  = 8'h00;
        io_rdata  = 8'h00;
        if_rdy    = 1'b1;
        dm_rdy    = 1'b1;
        io_rdy    = 1'b1;
        stall_on  = 1'b0;
        errors    = 0;
        tests_run = 0;
        timed_out = 1'b0;
        $readmemh("tests/bfcpu_testdata.txt", tdata);
        ntests = int'(tdata[0]);
        rp     = 1;
        for (int t = 1; t <= ntests && !timed_out; t++)
            run_test(t);
        $display("%0d tests run, %0d check errors", tests_run, errors);
        if (errors == 0 && !timed_out)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

//--- tests/bfcpu_assert.sv
//------------------------------
// Bus rule checks on the core top level
// Bound into every bfcpu instance
//------------------------------
`timescale 1ns/1ns

module bfcpu_assert (
    input logic        CLK,
    input logic        RES,
    input logic        if_req,
    input logic [15:0] if_addr,
    input logic        if_rdy,
    input logic        dm_req,
    input logic        dm_rdy,
    input logic        io_req,
    input logic        io_rdy
);

    logic slot;

    assign slot = if_rdy & dm_rdy & io_rdy;

    // Data and I/O never share a cycle
    a_excl: assert property (@(posedge CLK) disable iff (RES) !(dm_req && io_req))
        else $error("dm_req and io_req high together");

    // Back-pressure masks all requests
    a_mask: assert property (@(posedge CLK) disable iff (RES)
        !slot |-> !(if_req || dm_req || io_req))
        else $error("request high while a ready is low");

    // pc frozen outside slot cycles
    a_hold: assert property (@(posedge CLK) disable iff (RES) !slot |=> $stable(if_addr))
        else $error("if_addr moved during a stall");

    // First cycle out of reset only fetches
    a_first: assert property (@(posedge CLK) $fell(RES) |-> !(dm_req || io_req))
        else $error("data or I/O request right after reset");

endmodule

bind bfcpu bfcpu_assert assert_i (
    .CLK(CLK), .RES(RES),
    .if_req(if_req), .if_addr(if_addr), .if_rdy(if_rdy),
    .dm_req(dm_req), .dm_rdy(dm_rdy),
    .io_req(io_req), .io_rdy(io_rdy)
);

//--- tests/tb_clock.sv
//------------------------------
// Clock and reset source
// Reset held 2 cycles at start and on each request
//------------------------------
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 8
) (
    input  logic reset_req,
    output logic CLK,
    output logic RES
);

    initial
    begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    // Power-on reset, then reset again on request
    initial
    begin
        RES = 1'b1;
        repeat (2) @(posedge CLK);
        RES <= 1'b0;
        forever
        begin
            @(posedge CLK);
            if (reset_req)
            begin
                RES <= 1'b1;
                repeat (2) @(posedge CLK);
                RES <= 1'b0;
            end
        end
    end

endmodule

//--- logic/bfcpu.sv
//------------------------------
// Core top level with fetch, data and I/O buses
// Any ready low freezes the whole core
// All I/O accesses go to port address 0
// Data memory must read as zero before a run
//------------------------------
`timescale 1ns/1ns
`include "bfcpu_defs.svh"

module bfcpu (
    input  logic               CLK,
    input  logic               RES,
    // Fetch bus
    output logic               if_req,
    output logic [`PC_W-1:0]   if_addr,
    input  logic [`OP_W-1:0]   if_code,
    input  logic               if_rdy,
    // Data memory bus
    output logic               dm_req,
    output logic               dm_write,
    output logic [`PTR_W-1:0]  dm_addr,
    output logic [`CELL_W-1:0] dm_wdata,
    input  logic [`CELL_W-1:0] dm_rdata,
    input  logic               dm_rdy,
    // I/O bus
    output logic               io_req,
    output logic               io_write,
    output logic [`CELL_W-1:0] io_wdata,
    input  logic [`CELL_W-1:0] io_rdata,
    input  logic               io_rdy
);

    logic               slot;
    logic               if_do;
    logic               dr_do;
    logic               dw_do;
    logic               ir_do;
    logic               iw_do;
    logic [`OP_W-1:0]   opcode;
    logic [`CELL_W-1:0] dm_data;
    logic [`CELL_W-1:0] io_data;
    logic [`CELL_W-1:0] alu_out;

    //------------------------------
    // Slot and request masking
    //------------------------------
    assign slot     = if_rdy & dm_rdy & io_rdy;
    assign if_req   = if_do & slot;
    assign dm_req   = (dr_do | dw_do) & slot;
    assign dm_write = dw_do;
    assign io_req   = (ir_do | iw_do) & slot;
    assign io_write = iw_do;
    // One ALU result feeds both write buses
    assign dm_wdata = alu_out;
    assign io_wdata = alu_out;

    ctl_if ctl_i ();

    exec_datapath datapath_i (
        .CLK(CLK), .RES(RES), .slot(slot), .ctl(ctl_i.dp),
        .dm_data(dm_data), .io_data(io_data),
        .pc(if_addr), .ptr(dm_addr), .alu_out(alu_out)
    );

    sequencer sequencer_i (
        .CLK(CLK), .RES(RES), .slot(slot), .opcode(opcode), .ctl(ctl_i.seq),
        .if_do(if_do), .dr_do(dr_do), .dw_do(dw_do), .ir_do(ir_do), .iw_do(iw_do)
    );

    // Fetch holds NOP after reset
    bus_capture #(.DATA_W(`OP_W), .KEEP_INIT(`OP_RESET_KEEP)) if_capture_i (
        .CLK(CLK), .RES(RES), .read_req(if_do), .rdy(if_rdy), .slot(slot),
        .rdata(if_code), .data(opcode)
    );

    bus_capture #(.DATA_W(`CELL_W), .KEEP_INIT(`CELL_W'(0))) dm_capture_i (
        .CLK(CLK), .RES(RES), .read_req(dr_do), .rdy(dm_rdy), .slot(slot),
        .rdata(dm_rdata), .data(dm_data)
    );

    bus_capture #(.DATA_W(`CELL_W), .KEEP_INIT(`CELL_W'(0))) io_capture_i (
        .CLK(CLK), .RES(RES), .read_req(ir_do), .rdy(io_rdy), .slot(slot),
        .rdata(io_rdata), .data(io_data)
    );

endmodule

//--- logic/sequencer.sv
//------------------------------
// Opcode decode and multi-step instruction FSM
// Opcode input must hold across stalls
// Loop scans refetch one nibble per step
// State only advances in a slot cycle
//------------------------------
`timescale 1ns/1ns
`include "bfcpu_defs.svh"

module sequencer import bfcpu_pkg::*; (
    input  logic    CLK,
    input  logic    RES,
    input  logic    slot,
    input  opcode_u opcode,
    ctl_if.seq      ctl,
    output logic    if_do,
    output logic    dr_do,
    output logic    dw_do,
    output logic    ir_do,
    output logic    iw_do
);

    // Pair indices taken from the opcode codes
    localparam opcode_u PAIR_PTR  = `OP_PINC;
    localparam opcode_u PAIR_CELL = `OP_INC;
    localparam opcode_u PAIR_IO   = `OP_OUT;
    localparam opcode_u PAIR_LOOP = `OP_BEGIN;

    seq_state_t state;
    seq_state_t state_next;
    logic       step;
    logic       step_next;

    always_ff @(posedge CLK or posedge RES)
    begin
        if (RES)
        begin
            state <= ST_DECODE;
            step  <= 1'b0;
        end
        else if (slot)
        begin
            state <= state_next;
            step  <= step_next;
        end
    end

    //------------------------------
    // ALU control
    //------------------------------
    // Depends on state only
    always_comb
    begin
        ctl.alu_from_io = (state == ST_IN);
        case (state)
            ST_INC:                        ctl.alu_func = ALU_INC;
            ST_DEC:                        ctl.alu_func = ALU_DEC;
            ST_OUT, ST_IN, ST_BEGIN, ST_END: ctl.alu_func = ALU_THRU;
            default:                       ctl.alu_func = ALU_ZERO;
        endcase
    end

    //------------------------------
    // Next state and bus requests
    //------------------------------
    always_comb
    begin
        // Idle defaults
        state_next   = ST_DECODE;
        step_next    = 1'b0;
        if_do        = 1'b0;
        dr_do        = 1'b0;
        dw_do        = 1'b0;
        ir_do        = 1'b0;
        iw_do        = 1'b0;
        ctl.pc_op    = CNT_HOLD;
        ctl.ptr_op   = CNT_HOLD;
        ctl.depth_op = CNT_HOLD;
        case (state)
            ST_DECODE:
            begin
                case (opcode.f.pair)
                    // Pointer move, done here
                    PAIR_PTR.f.pair:
                    begin
                        ctl.ptr_op = opcode.f.dir ? CNT_DEC : CNT_INC;
                        if_do      = 1'b1;
                        ctl.pc_op  = CNT_INC;
                    end
                    PAIR_CELL.f.pair:
                    begin
                        dr_do      = 1'b1;
                        state_next = opcode.f.dir ? ST_DEC : ST_INC;
                    end
                    // OUT reads the cell, IN reads the port
                    PAIR_IO.f.pair:
                    begin
                        dr_do      = ~opcode.f.dir;
                        ir_do      = opcode.f.dir;
                        state_next = opcode.f.dir ? ST_IN : ST_OUT;
                    end
                    PAIR_LOOP.f.pair:
                    begin
                        dr_do      = 1'b1;
                        state_next = opcode.f.dir ? ST_END : ST_BEGIN;
                    end
                    // NOP and unused codes
                    default:
                    begin
                        if_do     = 1'b1;
                        ctl.pc_op = CNT_INC;
                    end
                endcase
            end
            // Write back the changed cell
            ST_INC, ST_DEC, ST_IN:
            begin
                dw_do     = 1'b1;
                if_do     = 1'b1;
                ctl.pc_op = CNT_INC;
            end
            ST_OUT:
            begin
                iw_do     = 1'b1;
                if_do     = 1'b1;
                ctl.pc_op = CNT_INC;
            end
            // Zero cell starts the forward skip
            ST_BEGIN:
            begin
                if_do     = 1'b1;
                ctl.pc_op = CNT_INC;
                if (ctl.alu_zero)
                begin
                    ctl.depth_op = CNT_CLR;
                    state_next   = ST_SKIP_FWD;
                end
            end
            ST_SKIP_FWD:
            begin
                if_do      = 1'b1;
                ctl.pc_op  = CNT_INC;
                state_next = ST_SKIP_FWD;
                if (opcode.code == `OP_END && ctl.depth_zero)
                    state_next = ST_DECODE;
                else if (opcode.code == `OP_END && ctl.depth_plus)
                    ctl.depth_op = CNT_DEC;
                else if (opcode.code == `OP_BEGIN)
                    ctl.depth_op = CNT_INC;
            end
            // Nonzero cell, back up to just before END
            ST_END:
            begin
                if (ctl.alu_zero)
                begin
                    if_do     = 1'b1;
                    ctl.pc_op = CNT_INC;
                end
                else
                begin
                    ctl.pc_op    = CNT_DEC2;
                    ctl.depth_op = CNT_CLR;
                    state_next   = ST_SCAN_BACK;
                end
            end
            // Step 0 fetches only, step 1 checks each nibble
            ST_SCAN_BACK:
            begin
                if (step && opcode.code == `OP_BEGIN && ctl.depth_zero)
                begin
                    ctl.pc_op  = CNT_INC2;
                    state_next = ST_RESUME;
                end
                else
                begin
                    if_do      = 1'b1;
                    ctl.pc_op  = CNT_DEC;
                    step_next  = 1'b1;
                    state_next = ST_SCAN_BACK;
                    if (step && opcode.code == `OP_BEGIN && ctl.depth_plus)
                        ctl.depth_op = CNT_DEC;
                    else if (step && opcode.code == `OP_END)
                        ctl.depth_op = CNT_INC;
                end
            end
            // pc is past the matched BEGIN
            ST_RESUME:
            begin
                if_do     = 1'b1;
                ctl.pc_op = CNT_INC;
            end
            default:
            begin
                state_next = ST_DECODE;
            end
        endcase
    end

endmodule

//--- logic/exec_datapath.sv
//------------------------------
// Program counter, data pointer, depth counter and ALU
// All registers move only in a slot cycle
// Pointer and pc wrap at their width
//------------------------------
`timescale 1ns/1ns
`include "bfcpu_defs.svh"

module exec_datapath import bfcpu_pkg::*; (
    input  logic               CLK,
    input  logic               RES,
    input  logic               slot,
    ctl_if.dp                  ctl,
    input  logic [`CELL_W-1:0] dm_data,
    input  logic [`CELL_W-1:0] io_data,
    output logic [`PC_W-1:0]   pc,
    output logic [`PTR_W-1:0]  ptr,
    output logic [`CELL_W-1:0] alu_out
);

    logic [`DEPTH_W-1:0] depth;
    logic [`CELL_W-1:0]  alu_in;

    // Signed step of a counter operation
    // CLR is handled by the caller
    function automatic logic signed [2:0] cnt_step(input cnt_op_t op);
        logic signed [2:0] step;
        case (op)
            CNT_INC:  step = 3'sd1;
            CNT_DEC:  step = -3'sd1;
            CNT_INC2: step = 3'sd2;
            CNT_DEC2: step = -3'sd2;
            default:  step = 3'sd0;
        endcase
        return step;
    endfunction

    //------------------------------
    // Counters
    //------------------------------
    always_ff @(posedge CLK or posedge RES)
    begin
        if (RES)
            pc <= '0;
        else if (slot)
        begin
            if (ctl.pc_op == CNT_CLR)
                pc <= '0;
            else
                pc <= pc + `PC_W'(cnt_step(ctl.pc_op));
        end
    end

    always_ff @(posedge CLK or posedge RES)
    begin
        if (RES)
            ptr <= '0;
        else if (slot)
        begin
            if (ctl.ptr_op == CNT_CLR)
                ptr <= '0;
            else
                ptr <= ptr + `PTR_W'(cnt_step(ctl.ptr_op));
        end
    end

    // Bracket nesting depth during a loop scan
    always_ff @(posedge CLK or posedge RES)
    begin
        if (RES)
            depth <= '0;
        else if (slot)
        begin
            if (ctl.depth_op == CNT_CLR)
                depth <= '0;
            else
                depth <= depth + `DEPTH_W'(cnt_step(ctl.depth_op));
        end
    end

    assign ctl.depth_zero = (depth == '0);
    // Positive means sign clear and not zero
    assign ctl.depth_plus = ~depth[`DEPTH_W-1] & (|depth[`DEPTH_W-2:0]);

    //------------------------------
    // ALU
    //------------------------------
    assign alu_in = ctl.alu_from_io ? io_data : dm_data;

    always_comb
    begin
        case (ctl.alu_func)
            ALU_ZERO: alu_out = '0;
            ALU_THRU: alu_out = alu_in;
            ALU_INC:  alu_out = alu_in + `CELL_W'(1);
            ALU_DEC:  alu_out = alu_in - `CELL_W'(1);
        endcase
    end

    // Loop tests look at the passed cell
    assign ctl.alu_zero = (alu_out == '0);

endmodule

//--- logic/bus_capture.sv
//------------------------------
// Read data holder for one request/ready bus
// read_req is the unmasked read intent of the core
// Data is live only in the cycle its data phase ends
//------------------------------
`timescale 1ns/1ns
`include "bfcpu_defs.svh"

module bus_capture #(
    parameter int                DATA_W    = `CELL_W,
    parameter logic [DATA_W-1:0] KEEP_INIT = '0
) (
    input  logic              CLK,
    input  logic              RES,
    input  logic              read_req,
    input  logic              rdy,
    input  logic              slot,
    input  logic [DATA_W-1:0] rdata,
    output logic [DATA_W-1:0] data
);

    logic              pending;
    logic [DATA_W-1:0] keep;

    // Data phase follows an accepted read
    // Cleared once this bus is ready again
    always_ff @(posedge CLK or posedge RES)
    begin
        if (RES)
            pending <= 1'b0;
        else if (read_req && slot)
            pending <= 1'b1;
        else if (rdy)
            pending <= 1'b0;
    end

    // Hold the byte while other buses stall
    always_ff @(posedge CLK or posedge RES)
    begin
        if (RES)
            keep <= KEEP_INIT;
        else if (pending && rdy)
            keep <= rdata;
    end

    assign data = (pending && rdy) ? rdata : keep;

endmodule

//--- logic/ctl_if.sv
//------------------------------
// Control and flag signals between sequencer and datapath
// No clock, all signals combinational
//------------------------------
`timescale 1ns/1ns

interface ctl_if import bfcpu_pkg::*; ();

    // Sequencer to datapath
    cnt_op_t   pc_op;
    cnt_op_t   ptr_op;
    cnt_op_t   depth_op;
    alu_func_t alu_func;
    logic      alu_from_io;

    // Datapath to sequencer
    logic      alu_zero;
    logic      depth_zero;
    logic      depth_plus;

    modport seq (output pc_op, ptr_op, depth_op, alu_func, alu_from_io,
                 input  alu_zero, depth_zero, depth_plus);

    modport dp  (input  pc_op, ptr_op, depth_op, alu_func, alu_from_io,
                 output alu_zero, depth_zero, depth_plus);

endinterface

//--- logic/bfcpu_pkg.sv
//------------------------------
// Types shared by the core blocks
// Needs the defs header on the include path
//------------------------------
`include "bfcpu_defs.svh"

package bfcpu_pkg;

    // Sequencer states
    // SCAN_BACK and RESUME only follow END
    typedef enum logic [3:0] {
        ST_DECODE, ST_INC, ST_DEC, ST_OUT, ST_IN,
        ST_BEGIN, ST_END, ST_SKIP_FWD, ST_SCAN_BACK, ST_RESUME
    } seq_state_t;

    // ALU functions
    typedef enum logic [1:0] {ALU_ZERO, ALU_THRU, ALU_INC, ALU_DEC} alu_func_t;

    // Counter operations for pc, pointer and depth
    typedef enum logic [2:0] {CNT_HOLD, CNT_CLR, CNT_INC, CNT_DEC, CNT_INC2, CNT_DEC2} cnt_op_t;

    // Opcode nibble, whole code or pair index plus direction
    typedef union packed {
        logic [`OP_W-1:0] code;
        struct packed {
            logic [`OP_W-2:0] pair;
            logic             dir;
        } f;
    } opcode_u;

endpackage

//--- logic/bfcpu_defs.svh
//------------------------------
// Widths and opcode codes of the core
// Codes 8 to 14 are unused and run as no operation
// Code pairs share bits 3:1, bit 0 picks the direction
//------------------------------
`ifndef BFCPU_DEFS_SVH
`define BFCPU_DEFS_SVH

// Bus widths
`define PC_W     16
`define PTR_W    15
`define OP_W     4
`define CELL_W   8
`define DEPTH_W  16

// Opcode values
`define OP_PINC  4'h0
`define OP_PDEC  4'h1
`define OP_INC   4'h2
`define OP_DEC   4'h3
`define OP_OUT   4'h4
`define OP_IN    4'h5
`define OP_BEGIN 4'h6
`define OP_END   4'h7
`define OP_NOP   4'hf

// Held opcode after reset, forces the first fetch
`define OP_RESET_KEEP `OP_NOP

`endif
